// File: common/usrp_rx_macros.svh
`ifndef USRP_RX_MACROS_SVH
`define USRP_RX_MACROS_SVH

// Settings bus register addresses
`define FR_MODE        7'd1
`define FR_DECIM_RATE  7'd2

// Receive FIFO depth in samples
`define RX_FIFO_DEPTH  16

// Arithmetic right shift applied to the decimator accumulator
`define RX_OUT_SHIFT   4

`endif

// File: common/usrp_rx_pkg.sv
package usrp_rx_pkg;

   // Raw ADC sample pair, one per clk64 cycle
   typedef struct packed {
      logic signed [11:0] i;
      logic signed [11:0] q;
   } adc_iq_t;

   // Baseband sample after decimation
   typedef struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
   } iq_sample_t;

   // Mode register payload
   typedef struct packed {
      logic counter_mode;
   } mode_cfg_t;

   // Decimation register payload, factor is decim_rate + 1
   typedef struct packed {
      logic       enable_rx;
      logic [7:0] decim_rate;
   } decim_cfg_t;

   // One write on the settings bus
   typedef struct packed {
      logic        strobe;
      logic [6:0]  addr;
      logic [31:0] data;
   } settings_bus_t;

endpackage

// File: hw/setting_reg.sv
module setting_reg
   import usrp_rx_pkg::*;
#(
   parameter int  ADDR = 0,
   parameter type payload_t = logic
)
(
   input  logic          clk64,
   input  logic          rx_dsp_reset,
   input  settings_bus_t i_settings,
   output payload_t      o_value
);

   localparam int PW = $bits(payload_t);

   logic hit;

   // Write only when the strobe carries our address
   assign hit = i_settings.strobe && (i_settings.addr == ADDR[6:0]);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         o_value <= '0;
      else if (hit)
         o_value <= payload_t'(i_settings.data[PW-1:0]);
   end

endmodule

// File: hw/master_control.sv
module master_control
   import usrp_rx_pkg::*;
(
   input  logic       clk64,
   input  logic       rx_dsp_reset,
   input  decim_cfg_t i_decim,
   output logic       o_rx_enable,
   output logic       o_strobe_decim
);

   logic [7:0] phase;
   logic [7:0] rate_q;
   logic       wrap;

   // Top of the decimation period
   assign wrap = (phase == rate_q);

   assign o_strobe_decim = o_rx_enable && wrap;

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         o_rx_enable <= 1'b0;
      else
         o_rx_enable <= i_decim.enable_rx;
   end

   // Phase counter runs 0 to rate_q while enabled
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         phase <= '0;
      else if (!o_rx_enable)
         phase <= '0;
      else if (wrap)
         phase <= '0;
      else
         phase <= phase + 8'd1;
   end

   // New rate is picked up while idle or at a wrap
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         rate_q <= '0;
      else if (!o_rx_enable || wrap)
         rate_q <= i_decim.decim_rate;
   end

endmodule

// File: rx_chain/rx_decimator.sv
`include "usrp_rx_macros.svh"

module rx_decimator
   import usrp_rx_pkg::*;
(
   input  logic       clk64,
   input  logic       rx_dsp_reset,
   input  logic       i_enable,
   input  logic       i_strobe,
   input  adc_iq_t    i_adc,
   output iq_sample_t o_bb,
   output logic       o_bb_valid
);

   logic signed [23:0] acc_i;
   logic signed [23:0] acc_q;
   logic signed [23:0] sum_i;
   logic signed [23:0] sum_q;
   logic signed [23:0] scaled_i;
   logic signed [23:0] scaled_q;
   logic               dump;

   // Running sum including the sample present this cycle
   assign sum_i = acc_i + {{12{i_adc.i[11]}}, i_adc.i};
   assign sum_q = acc_q + {{12{i_adc.q[11]}}, i_adc.q};

   assign scaled_i = sum_i >>> `RX_OUT_SHIFT;
   assign scaled_q = sum_q >>> `RX_OUT_SHIFT;

   assign dump = i_enable && i_strobe;

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !i_enable)
      begin
         acc_i      <= '0;
         acc_q      <= '0;
         o_bb_valid <= 1'b0;
      end
      else if (i_strobe)
      begin
         // Restart the block after a dump
         acc_i      <= '0;
         acc_q      <= '0;
         o_bb_valid <= 1'b1;
      end
      else
      begin
         acc_i      <= sum_i;
         acc_q      <= sum_q;
         o_bb_valid <= 1'b0;
      end
   end

   // Output word holds between dumps
   always_ff @(posedge clk64)
   begin
      if (dump)
      begin
         o_bb.i <= scaled_i[15:0];
         o_bb.q <= scaled_q[15:0];
      end
   end

endmodule

// File: rx_chain/rx_source_select.sv
module rx_source_select
   import usrp_rx_pkg::*;
(
   input  logic       clk64,
   input  logic       rx_dsp_reset,
   input  mode_cfg_t  i_mode,
   input  logic       i_enable,
   input  iq_sample_t i_bb,
   input  logic       i_bb_valid,
   output iq_sample_t o_src,
   output logic       o_src_valid
);

   logic [15:0] debug_counter;

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         debug_counter <= '0;
         o_src_valid   <= 1'b0;
      end
      else
      begin
         o_src_valid <= i_bb_valid;
         // Pattern restarts from zero on every enable
         if (!i_enable)
            debug_counter <= '0;
         else if (i_bb_valid)
            debug_counter <= debug_counter + 16'd2;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (i_mode.counter_mode)
      begin
         o_src.i <= signed'(debug_counter);
         o_src.q <= signed'(debug_counter + 16'd1);
      end
      else
         o_src <= i_bb;
   end

endmodule

// File: rx_buffer/rx_buffer.sv
`include "usrp_rx_macros.svh"

module rx_buffer
   import usrp_rx_pkg::*;
(
   input  logic       clk64,
   input  logic       rx_dsp_reset,
   input  iq_sample_t i_sample,
   input  logic       i_valid,
   input  logic       i_host_ack,
   input  logic       i_clear_status,
   output logic       o_host_req,
   output iq_sample_t o_host_data,
   output logic       o_rx_overrun
);

   localparam int AW = $clog2(`RX_FIFO_DEPTH);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_ACK_LOW
   } host_state_t;

   iq_sample_t  mem [`RX_FIFO_DEPTH];
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic        empty;
   logic        full;
   logic        push;
   logic        pop;
   host_state_t state;

   // Extra pointer bit tells full from empty
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);
   assign push  = i_valid && !full;
   assign pop   = (state == ST_REQ) && i_host_ack;

   always_ff @(posedge clk64)
   begin
      if (push)
         mem[wr_ptr[AW-1:0]] <= i_sample;
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Sticky until the host clears status; a new drop wins over the clear
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         o_rx_overrun <= 1'b0;
      else if (i_valid && full)
         o_rx_overrun <= 1'b1;
      else if (i_clear_status)
         o_rx_overrun <= 1'b0;
   end

   // Four-phase host handshake
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         state <= ST_IDLE;
      else
      begin
         case (state)
            ST_IDLE:
               if (!empty && !i_host_ack)
                  state <= ST_REQ;
            ST_REQ:
               if (i_host_ack)
                  state <= ST_ACK_LOW;
            ST_ACK_LOW:
               if (!i_host_ack)
                  state <= empty ? ST_IDLE : ST_REQ;
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   assign o_host_req  = (state == ST_REQ);
   // Head entry cannot change until it is popped
   assign o_host_data = mem[rd_ptr[AW-1:0]];

endmodule

// File: hw/usrp_rx_top.sv
`include "usrp_rx_macros.svh"

module usrp_rx_top
   import usrp_rx_pkg::*;
(
   input  logic          clk64,
   input  logic          rx_dsp_reset,
   input  settings_bus_t i_settings,
   input  adc_iq_t       i_adc,
   input  logic          i_host_ack,
   input  logic          i_clear_status,
   output logic          o_host_req,
   output iq_sample_t    o_host_data,
   output logic          o_rx_overrun
);

   mode_cfg_t  o_mode;
   decim_cfg_t o_decim;
   logic       rx_enable;
   logic       strobe_decim;
   iq_sample_t bb;
   logic       bb_valid;
   iq_sample_t src;
   logic       src_valid;

   setting_reg #(
      .ADDR      (`FR_MODE),
      .payload_t (mode_cfg_t)
   ) sr_mode (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_settings   (i_settings),
      .o_value      (o_mode)
   );

   setting_reg #(
      .ADDR      (`FR_DECIM_RATE),
      .payload_t (decim_cfg_t)
   ) sr_decim (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_settings   (i_settings),
      .o_value      (o_decim)
   );

   master_control u_master_control (
      .clk64          (clk64),
      .rx_dsp_reset   (rx_dsp_reset),
      .i_decim        (o_decim),
      .o_rx_enable    (rx_enable),
      .o_strobe_decim (strobe_decim)
   );

   rx_decimator u_rx_decimator (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_enable     (rx_enable),
      .i_strobe     (strobe_decim),
      .i_adc        (i_adc),
      .o_bb         (bb),
      .o_bb_valid   (bb_valid)
   );

   rx_source_select u_rx_source_select (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_mode       (o_mode),
      .i_enable     (rx_enable),
      .i_bb         (bb),
      .i_bb_valid   (bb_valid),
      .o_src        (src),
      .o_src_valid  (src_valid)
   );

   rx_buffer u_rx_buffer (
      .clk64          (clk64),
      .rx_dsp_reset   (rx_dsp_reset),
      .i_sample       (src),
      .i_valid        (src_valid),
      .i_host_ack     (i_host_ack),
      .i_clear_status (i_clear_status),
      .o_host_req     (o_host_req),
      .o_host_data    (o_host_data),
      .o_rx_overrun   (o_rx_overrun)
   );

endmodule

// File: verification/tb_clkgen.sv
module tb_clkgen
#(
   parameter int PERIOD       = 8,
   parameter int RESET_CYCLES = 10
)
(
   output logic clk64,
   output logic rx_dsp_reset
);

   initial
   begin
      clk64 = 1'b0;
      forever #(PERIOD / 2) clk64 = ~clk64;
   end

   // Reset drops on a falling edge, away from the sampling edge
   initial
   begin
      rx_dsp_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk64);
      @(negedge clk64);
      rx_dsp_reset = 1'b0;
   end

endmodule

// File: verification/usrp_rx_chk.sv
module usrp_rx_chk
   import usrp_rx_pkg::*;
(
   input logic       clk64,
   input logic       rx_dsp_reset,
   input logic       i_host_ack,
   input logic       o_host_req,
   input iq_sample_t o_host_data
);

   // Request holds until the host acknowledges
   a_req_held: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      o_host_req && !i_host_ack |=> o_host_req)
      else $error("o_host_req dropped before i_host_ack");

   // Head word is frozen while it is offered
   a_data_stable: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      o_host_req && !i_host_ack |=> $stable(o_host_data))
      else $error("o_host_data changed while o_host_req was high");

   // A new request only after ack has gone low
   a_req_rise: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      $rose(o_host_req) |-> !$past(i_host_ack))
      else $error("o_host_req rose while i_host_ack was high");

   a_req_reset: assert property (@(posedge clk64)
      rx_dsp_reset && $past(rx_dsp_reset) |-> !o_host_req)
      else $error("o_host_req high during reset");

endmodule

bind rx_buffer usrp_rx_chk u_usrp_rx_chk (
   .clk64        (clk64),
   .rx_dsp_reset (rx_dsp_reset),
   .i_host_ack   (i_host_ack),
   .o_host_req   (o_host_req),
   .o_host_data  (o_host_data)
);

// File: verification/usrp_rx_tb.sv
`include "usrp_rx_macros.svh"

module usrp_rx_tb
   import usrp_rx_pkg::*;
();

   localparam int CLK_PERIOD  = 8;
   localparam int MAX_FACTOR  = 10;
   // Enabled and idle cycles driven by the test sequence
   localparam int RUN_SAMPLES = 750;
   localparam int WATCHDOG_CYCLES = RUN_SAMPLES * MAX_FACTOR + 2000;

   logic          clk64;
   logic          rx_dsp_reset;
   settings_bus_t i_settings;
   adc_iq_t       i_adc;
   logic          i_host_ack;
   logic          i_clear_status;
   logic          o_host_req;
   iq_sample_t    o_host_data;
   logic          o_rx_overrun;

   adc_iq_t     adc_log[$];
   iq_sample_t  exp_q[$];
   iq_sample_t  rx_q[$];
   logic [31:0] lcg_state = 32'd99;
   int          en_idx;
   int          dis_idx;
   int          rate;
   int          blk;
   int          cap;
   bit          active;
   bit          counter_on;
   bit          host_hold;

   tb_clkgen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) u_tb_clkgen (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset)
   );

   usrp_rx_top u_usrp_rx_top (
      .clk64          (clk64),
      .rx_dsp_reset   (rx_dsp_reset),
      .i_settings     (i_settings),
      .i_adc          (i_adc),
      .i_host_ack     (i_host_ack),
      .i_clear_status (i_clear_status),
      .o_host_req     (o_host_req),
      .o_host_data    (o_host_data),
      .o_rx_overrun   (o_rx_overrun)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Expected word for the block whose last sample has index last
   function automatic iq_sample_t ref_word(int last, int r, bit cnt_mode, int n);
      iq_sample_t w;
      int         si;
      int         sq;
      si = 0;
      sq = 0;
      if (cnt_mode)
      begin
         w.i = 16'(2 * n);
         w.q = 16'(2 * n + 1);
      end
      else
      begin
         for (int k = last - r; k <= last; k++)
         begin
            si = si + int'(adc_log[k].i);
            sq = sq + int'(adc_log[k].q);
         end
         w.i = 16'(si >>> `RX_OUT_SHIFT);
         w.q = 16'(sq >>> `RX_OUT_SHIFT);
      end
      return w;
   endfunction

   task automatic end_with_failure(string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_sample(string name, iq_sample_t got, iq_sample_t exp);
      if (got !== exp)
         end_with_failure($sformatf("ERROR time=%0t %s got (%0d,%0d) expected (%0d,%0d)",
                                    $time, name, got.i, got.q, exp.i, exp.q));
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp)
         end_with_failure($sformatf("ERROR time=%0t %s got %b expected %b",
                                    $time, name, got, exp));
   endtask

   // One clk64 cycle of stimulus, the sample gets the index of the next rising edge
   task automatic next_cycle(settings_bus_t wr, logic clr);
      adc_iq_t     s;
      logic [31:0] r;
      int          cyc;
      int          first;
      @(negedge clk64);
      r = lcg_next();
      s.i = r[31:20];
      r = lcg_next();
      s.q = r[31:20];
      i_adc = s;
      i_settings = wr;
      i_clear_status = clr;
      adc_log.push_back(s);
      cyc = adc_log.size() - 1;
      if (wr.strobe && wr.addr == `FR_MODE)
         counter_on = wr.data[0];
      if (wr.strobe && wr.addr == `FR_DECIM_RATE)
      begin
         if (wr.data[8])
         begin
            active = 1'b1;
            en_idx = cyc;
            rate = int'(wr.data[7:0]);
            blk = 0;
            dis_idx = 1 << 30;
         end
         else if (active)
            dis_idx = cyc;
      end
      // Register, then enable, then first sample one cycle after enable rises
      first = en_idx + 2 + rate;
      if (active && cyc <= dis_idx + 1 && cyc >= first && (cyc - first) % (rate + 1) == 0)
      begin
         if (blk < cap)
            exp_q.push_back(ref_word(cyc, rate, counter_on, blk));
         blk++;
      end
      if (active && cyc > dis_idx + 1)
         active = 1'b0;
   endtask

   task automatic write_reg(logic [6:0] addr, logic [31:0] data);
      settings_bus_t wr;
      wr.strobe = 1'b1;
      wr.addr = addr;
      wr.data = data;
      next_cycle(wr, 1'b0);
   endtask

   task automatic run_cycles(int n);
      repeat (n) next_cycle('0, 1'b0);
   endtask

   task automatic run_session(bit cnt_mode, int r, int len, int limit);
      cap = limit;
      write_reg(`FR_MODE, {31'd0, cnt_mode});
      write_reg(`FR_DECIM_RATE, {23'd0, 1'b1, 8'(r)});
      run_cycles(len);
      write_reg(`FR_DECIM_RATE, {23'd0, 1'b0, 8'(r)});
      run_cycles(4);
   endtask

   task automatic drain_words();
      while (exp_q.size() > 0)
         next_cycle('0, 1'b0);
      run_cycles(8);
   endtask

   // Host side of the four-phase handshake
   initial
   begin
      int d;
      i_host_ack = 1'b0;
      forever
      begin
         @(negedge clk64);
         if (o_host_req && !host_hold)
         begin
            d = int'(lcg_next() >> 30);
            repeat (d) @(negedge clk64);
            rx_q.push_back(o_host_data);
            i_host_ack = 1'b1;
            @(negedge clk64);
            while (o_host_req)
               @(negedge clk64);
            d = int'(lcg_next() >> 30);
            repeat (d) @(negedge clk64);
            i_host_ack = 1'b0;
         end
      end
   end

   initial
   begin
      iq_sample_t got;
      forever
      begin
         @(negedge clk64);
         while (rx_q.size() > 0)
         begin
            got = rx_q.pop_front();
            if (exp_q.size() == 0)
               end_with_failure("The host received a word that the reference did not expect");
            else
               check_sample("o_host_data", got, exp_q.pop_front());
         end
      end
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      end_with_failure($sformatf("Watchdog expired after %0d cycles, the run did not finish",
                                 WATCHDOG_CYCLES));
   end

   initial
   begin
      i_settings = '0;
      i_adc = '0;
      i_clear_status = 1'b0;
      host_hold = 1'b0;
      active = 1'b0;
      counter_on = 1'b0;
      cap = 0;
      blk = 0;
      en_idx = 0;
      dis_idx = 0;
      rate = 0;
      @(negedge rx_dsp_reset);
      check_flag("o_host_req", o_host_req, 1'b0);
      check_flag("o_rx_overrun", o_rx_overrun, 1'b0);
      // Rate set but receiver left disabled
      write_reg(`FR_DECIM_RATE, {23'd0, 1'b0, 8'd3});
      repeat (40)
      begin
         next_cycle('0, 1'b0);
         check_flag("o_host_req", o_host_req, 1'b0);
      end
      run_session(1'b0, 3, 80, 1000);
      drain_words();
      run_session(1'b0, 9, 150, 1000);
      drain_words();
      check_flag("o_rx_overrun", o_rx_overrun, 1'b0);
      // Counter pattern restarts after disable and enable
      run_session(1'b1, 3, 40, 1000);
      run_session(1'b1, 3, 40, 1000);
      drain_words();
      // Host stalls for more outputs than the FIFO holds
      host_hold = 1'b1;
      run_session(1'b0, 3, 100, `RX_FIFO_DEPTH);
      check_flag("o_rx_overrun", o_rx_overrun, 1'b1);
      host_hold = 1'b0;
      drain_words();
      next_cycle('0, 1'b1);
      next_cycle('0, 1'b0);
      check_flag("o_rx_overrun", o_rx_overrun, 1'b0);
      run_session(1'b0, 9, 300, 1000);
      drain_words();
      check_flag("o_rx_overrun", o_rx_overrun, 1'b0);
      if (rx_q.size() == 0 && exp_q.size() == 0)
      begin
         $display("Simulation passed");
         $finish;
      end
      else
         end_with_failure("Words were left over between the host and the reference");
   end

endmodule

// File: flist.f
+incdir+common
common/usrp_rx_pkg.sv
hw/setting_reg.sv
hw/master_control.sv
rx_chain/rx_decimator.sv
rx_chain/rx_source_select.sv
rx_buffer/rx_buffer.sv
hw/usrp_rx_top.sv
verification/tb_clkgen.sv
verification/usrp_rx_chk.sv
verification/usrp_rx_tb.sv

// File: Makefile
TOP := usrp_rx_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
